// File: logic/cmd_receiver.sv
`timescale 1ns/1ps

module cmd_receiver import processorci_pkg::*; #(
    parameter int CMD_DEPTH = 4
) (
    input  logic      sys_clk,
    input  logic      reset_i,
    input  logic      cmd_valid_i,
    input  host_cmd_t cmd_i,
    input  logic      take_i,
    output logic      cmd_credit_o,
    output host_cmd_t head_o,
    output logic      head_valid_o
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    host_cmd_t          slots [CMD_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               pop;

    // Host only sends with a credit, so a push always has room
    assign pop          = take_i && head_valid_o;
    assign head_valid_o = (count != '0);
    assign head_o       = slots[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (cmd_valid_i) slots[wr_ptr] <= cmd_i;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            cmd_credit_o <= 1'b0;
        end else begin
            if (cmd_valid_i) begin
                if (wr_ptr == PTR_W'(CMD_DEPTH - 1)) wr_ptr <= '0;
                else wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(CMD_DEPTH - 1)) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            cmd_credit_o <= pop;  // Freed slot goes back to the host
        end
    end

endmodule

// File: logic/core_memory.sv
`timescale 1ns/1ps

module core_memory import processorci_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        sys_clk,
    input  logic        reset_i,
    input  mem_req_t    core_req_i,
    input  logic        core_stb_i,
    input  mem_req_t    host_req_i,
    input  logic        host_req_valid_i,
    output logic [31:0] core_data_o,
    output logic        core_ack_o,
    output logic        host_done_o,
    output logic [31:0] host_rdata_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic             core_go;
    logic             host_go;
    mem_req_t         req;
    logic [IDX_W-1:0] idx;
    logic [31:0]      new_word;

    // No ack in the cycle right after an ack, the master is dropping stb then
    assign core_go = core_stb_i && !core_ack_o;
    // Host waits for a cycle without a core access
    assign host_go = host_req_valid_i && !core_go && !host_done_o;

    assign req = core_go ? core_req_i : host_req_i;
    assign idx = req.addr[IDX_W+1:2];  // Word index, wraps modulo MEM_WORDS

    always_comb begin
        if (req.we) new_word = merge_word(mem[idx], req.data, req.wstrb);
        else new_word = mem[idx];
    end

    always_ff @(posedge sys_clk) begin
        if (core_go || host_go) begin
            if (req.we) mem[idx] <= new_word;
            if (core_go) core_data_o <= new_word;
            else host_rdata_o <= new_word;  // Word after any write
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            core_ack_o  <= 1'b0;
            host_done_o <= 1'b0;
        end else begin
            core_ack_o  <= core_go;
            host_done_o <= host_go;
        end
    end

endmodule

// File: logic/processorci_pkg.sv
package processorci_pkg;

    // Host command opcodes
    typedef enum logic [1:0] {
        CMD_WRITE = 2'd0,
        CMD_READ  = 2'd1,
        CMD_RUN   = 2'd2,  // Release core reset
        CMD_HALT  = 2'd3   // Assert core reset
    } cmd_op_e;

    // One command word from the host
    typedef struct packed {
        cmd_op_e     op;
        logic [3:0]  wstrb;
        logic [31:0] addr;   // Byte address, word index above bits 1:0
        logic [31:0] data;
    } host_cmd_t;

    // One response word back to the host
    typedef struct packed {
        cmd_op_e     op;     // Echo of the command opcode
        logic [31:0] data;
    } host_resp_t;

    // Memory access, used by both the host port and the core bus
    typedef struct packed {
        logic        we;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    // Byte-strobe merge of new data into an old word
    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

endpackage

// File: logic/processorci_top.sv
`timescale 1ns/1ps

module processorci_top import processorci_pkg::*; #(
    parameter int CMD_DEPTH    = 4,
    parameter int RESP_CREDITS = 2,
    parameter int MEM_WORDS    = 256
) (
    input  logic        sys_clk,
    input  logic        reset_i,
    input  logic        cmd_valid_i,
    input  host_cmd_t   cmd_i,
    output logic        cmd_credit_o,
    output logic        resp_valid_o,
    output host_resp_t  resp_o,
    input  logic        resp_credit_i,
    output logic        core_rst_o,    // High holds the core in reset
    input  logic        core_cyc_i,
    input  logic        core_stb_i,
    input  logic        core_we_i,
    input  logic [3:0]  core_wstrb_i,
    input  logic [31:0] core_addr_i,
    input  logic [31:0] core_data_i,
    output logic [31:0] core_data_o,
    output logic        core_ack_o
);

    host_cmd_t   head;
    logic        head_valid;
    logic        take;
    mem_req_t    host_req;
    logic        host_req_valid;
    logic        host_done;
    logic [31:0] host_rdata;
    logic        resp_push;
    host_resp_t  resp_int;
    logic        resp_full;
    mem_req_t    core_req;
    logic        core_strobe;

    // Wishbone lines into one request
    assign core_req    = '{we: core_we_i, wstrb: core_wstrb_i,
                           addr: core_addr_i, data: core_data_i};
    assign core_strobe = core_cyc_i && core_stb_i;

    cmd_receiver #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_receiver (
        .sys_clk      (sys_clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .take_i       (take),
        .cmd_credit_o (cmd_credit_o),
        .head_o       (head),
        .head_valid_o (head_valid)
    );

    test_controller u_test_controller (
        .sys_clk         (sys_clk),
        .reset_i         (reset_i),
        .head_i          (head),
        .head_valid_i    (head_valid),
        .mem_done_i      (host_done),
        .mem_rdata_i     (host_rdata),
        .resp_full_i     (resp_full),
        .take_o          (take),
        .mem_req_o       (host_req),
        .mem_req_valid_o (host_req_valid),
        .resp_push_o     (resp_push),
        .resp_o          (resp_int),
        .core_rst_o      (core_rst_o)
    );

    core_memory #(.MEM_WORDS(MEM_WORDS)) u_core_memory (
        .sys_clk          (sys_clk),
        .reset_i          (reset_i),
        .core_req_i       (core_req),
        .core_stb_i       (core_strobe),
        .host_req_i       (host_req),
        .host_req_valid_i (host_req_valid),
        .core_data_o      (core_data_o),
        .core_ack_o       (core_ack_o),
        .host_done_o      (host_done),
        .host_rdata_o     (host_rdata)
    );

    resp_sender #(.RESP_CREDITS(RESP_CREDITS)) u_resp_sender (
        .sys_clk       (sys_clk),
        .reset_i       (reset_i),
        .push_i        (resp_push),
        .resp_i        (resp_int),
        .resp_credit_i (resp_credit_i),
        .full_o        (resp_full),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o)
    );

endmodule

// File: logic/resp_sender.sv
`timescale 1ns/1ps

module resp_sender import processorci_pkg::*; #(
    parameter int RESP_CREDITS = 2
) (
    input  logic       sys_clk,
    input  logic       reset_i,
    input  logic       push_i,
    input  host_resp_t resp_i,
    input  logic       resp_credit_i,
    output logic       full_o,
    output logic       resp_valid_o,
    output host_resp_t resp_o
);

    localparam int CRD_W = $clog2(RESP_CREDITS + 1);

    host_resp_t       queue [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic [CRD_W-1:0] credits;

    assign full_o       = (count == 2'd2);
    // Send as soon as a response waits and a credit is held
    assign resp_valid_o = (count != 2'd0) && (credits != '0);
    assign resp_o       = queue[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (push_i) queue[wr_ptr] <= resp_i;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
            credits <= CRD_W'(RESP_CREDITS);
        end else begin
            if (push_i) wr_ptr <= ~wr_ptr;
            if (resp_valid_o) rd_ptr <= ~rd_ptr;
            case ({push_i, resp_valid_o})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Spend and return may happen together
            case ({resp_valid_o, resp_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: logic/test_controller.sv
`timescale 1ns/1ps

module test_controller import processorci_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset_i,
    input  host_cmd_t   head_i,
    input  logic        head_valid_i,
    input  logic        mem_done_i,
    input  logic [31:0] mem_rdata_i,
    input  logic        resp_full_i,
    output logic        take_o,
    output mem_req_t    mem_req_o,
    output logic        mem_req_valid_o,
    output logic        resp_push_o,
    output host_resp_t  resp_o,
    output logic        core_rst_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM,   // Waiting on the memory host port
        ST_RESP   // Push strobe high for one cycle
    } state_t;

    state_t  state;
    cmd_op_e op_q;
    logic    is_mem_op;

    // Start a command only when the response queue has room
    assign take_o    = (state == ST_IDLE) && head_valid_i && !resp_full_i;
    assign is_mem_op = (head_i.op == CMD_READ) || (head_i.op == CMD_WRITE);

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state           <= ST_IDLE;
            mem_req_valid_o <= 1'b0;
            resp_push_o     <= 1'b0;
            core_rst_o      <= 1'b1;  // Core held until a run command
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_o) begin
                        if (is_mem_op) begin
                            mem_req_valid_o <= 1'b1;
                            state           <= ST_MEM;
                        end else begin
                            core_rst_o  <= (head_i.op == CMD_HALT);
                            resp_push_o <= 1'b1;
                            state       <= ST_RESP;
                        end
                    end
                end
                ST_MEM: begin
                    if (mem_done_i) begin
                        mem_req_valid_o <= 1'b0;
                        resp_push_o     <= 1'b1;
                        state           <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    resp_push_o <= 1'b0;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge sys_clk) begin
        if (take_o) begin
            op_q            <= head_i.op;
            mem_req_o.we    <= (head_i.op == CMD_WRITE);
            mem_req_o.wstrb <= head_i.wstrb;
            mem_req_o.addr  <= head_i.addr;
            mem_req_o.data  <= head_i.data;
            if (!is_mem_op) begin
                resp_o.op   <= head_i.op;
                resp_o.data <= '0;  // Run and halt carry no data
            end
        end else if (state == ST_MEM && mem_done_i) begin
            resp_o.op   <= op_q;
            resp_o.data <= mem_rdata_i;
        end
    end

endmodule

// File: processorci_top.f
logic/processorci_pkg.sv
logic/cmd_receiver.sv
logic/test_controller.sv
logic/core_memory.sv
logic/resp_sender.sv
logic/processorci_top.sv
tests/processorci_tb_sva.sv
tests/processorci_tb.sv

// File: tests/processorci_tb.sv
`timescale 1ns/1ps

module processorci_tb import processorci_pkg::*; ();

    localparam int CMD_DEPTH    = 4;
    localparam int RESP_CREDITS = 2;
    localparam int MEM_WORDS    = 256;
    localparam int IDX_W        = $clog2(MEM_WORDS);
    localparam int NUM_CMDS     = 200;
    localparam int INIT_CMDS    = 32;   // Full-word writes over both halves
    localparam int MAX_CYCLES   = NUM_CMDS * 20 + 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        cmd_valid;
    host_cmd_t   cmd;
    logic        cmd_credit;
    logic        resp_valid;
    host_resp_t  resp;
    logic        resp_credit;
    logic        core_rst;
    logic        core_cyc;
    logic        core_stb;
    logic        core_we;
    logic [3:0]  core_wstrb;
    logic [31:0] core_addr;
    logic [31:0] core_wdata;
    logic [31:0] core_rdata;
    logic        core_ack;

    integer      seed = 32'h818c_fa08;
    int          cycle = 0;
    int          errors = 0;
    logic        started = 1'b0;
    host_cmd_t   sent_q [$];        // Commands awaiting their response
    int          credit_due [$];    // Cycle at which each response credit goes back
    logic [31:0] model [MEM_WORDS];
    int          cmd_credits = CMD_DEPTH;
    int          resp_crd = RESP_CREDITS;
    int          sent = 0;
    int          answered = 0;
    int          pend_core_reads = 0;
    int          pend_ctl = 0;
    logic        host_halted = 1'b1;
    logic        exp_rst = 1'b1;
    logic        core_busy = 1'b0;
    int          core_gap = 0;
    int          core_reqs = 0;
    int          core_acks = 0;

    processorci_top #(
        .CMD_DEPTH    (CMD_DEPTH),
        .RESP_CREDITS (RESP_CREDITS),
        .MEM_WORDS    (MEM_WORDS)
    ) u_dut (
        .sys_clk       (clk),
        .reset_i       (reset),
        .cmd_valid_i   (cmd_valid),
        .cmd_i         (cmd),
        .cmd_credit_o  (cmd_credit),
        .resp_valid_o  (resp_valid),
        .resp_o        (resp),
        .resp_credit_i (resp_credit),
        .core_rst_o    (core_rst),
        .core_cyc_i    (core_cyc),
        .core_stb_i    (core_stb),
        .core_we_i     (core_we),
        .core_wstrb_i  (core_wstrb),
        .core_addr_i   (core_addr),
        .core_data_i   (core_wdata),
        .core_data_o   (core_rdata),
        .core_ack_o    (core_ack)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Random upper bits exercise the address wrap
    function automatic logic [31:0] word_addr(input int idx, input logic [31:0] rnd);
        return {rnd[31:IDX_W+2], IDX_W'(idx), 2'b00};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send_cmd();
        host_cmd_t   c;
        logic [31:0] rnd;
        int          idx;
        rnd     = $random(seed);
        idx     = int'(rnd[7:4]);   // Host half is words 0 to 15
        c.op    = CMD_READ;
        c.wstrb = 4'hf;
        c.data  = $random(seed);
        c.addr  = word_addr(idx, $random(seed));
        if (sent < INIT_CMDS) begin
            c.op   = CMD_WRITE;
            c.addr = word_addr(sent, $random(seed));
        end else if (rnd[3:0] == 4'd0 && pend_core_reads == 0) begin
            c.op = CMD_RUN;
        end else if (rnd[3:0] <= 4'd1) begin
            c.op = CMD_HALT;
        end else if (rnd[3:0] <= 4'd8) begin
            c.op    = CMD_WRITE;
            c.wstrb = rnd[11:8];
        end else if (host_halted && rnd[3:0] >= 4'd13) begin
            c.addr = word_addr(idx + 16, $random(seed));  // Core half while the core is held
            pend_core_reads++;
        end
        if (c.op == CMD_RUN || c.op == CMD_HALT) begin
            pend_ctl++;
            host_halted = (c.op == CMD_HALT);
        end
        sent_q.push_back(c);
        cmd       = c;
        cmd_valid = 1'b1;
        cmd_credits--;
        sent++;
    endtask

    task automatic take_resp();
        host_cmd_t c;
        int        idx;
        check(resp_crd != 0, 1'b1, "response credit held");
        resp_crd--;
        if (sent_q.size() == 0) begin
            errors++;
            $display("Response arrived with no command outstanding at %0d ns", $time);
            return;
        end
        c   = sent_q.pop_front();
        idx = int'(c.addr[2 +: IDX_W]);
        check(resp.op, c.op, "response opcode");
        case (c.op)
            CMD_WRITE: begin
                model[idx] = apply_strobes(model[idx], c.data, c.wstrb);
                check(resp.data, model[idx], "write response");
            end
            CMD_READ: begin
                check(resp.data, model[idx], "read response");
                if (idx >= 16) pend_core_reads--;
            end
            default: begin
                check(resp.data, 32'd0, "run or halt response data");
                exp_rst = (c.op == CMD_HALT);
                pend_ctl--;
                if (pend_ctl == 0) check(core_rst, exp_rst, "core reset state");
            end
        endcase
        answered++;
        // Long credit stall in the middle of the run
        if (answered >= 120 && answered < 124) credit_due.push_back(cycle + 400);
        else credit_due.push_back(cycle + ($random(seed) & 7));
    endtask

    task automatic core_step();
        logic [31:0] rnd;
        int          idx;
        if (core_ack) begin
            core_acks++;
            if (!core_busy) begin
                errors++;
                $display("Core ack without an open request at %0d ns", $time);
            end else begin
                idx = int'(core_addr[2 +: IDX_W]);
                if (core_we) model[idx] = apply_strobes(model[idx], core_wdata, core_wstrb);
                check(core_rdata, model[idx], "core port data");
                core_cyc  = 1'b0;
                core_stb  = 1'b0;
                core_busy = 1'b0;
                core_gap  = $random(seed) & 3;
            end
        end else if (!core_busy) begin
            if (core_gap > 0) begin
                core_gap--;
            end else if (!core_rst && !exp_rst && answered < NUM_CMDS) begin
                rnd        = $random(seed);
                idx        = 16 + int'(rnd[8:5]);
                core_we    = rnd[0];
                core_wstrb = rnd[0] ? rnd[4:1] : 4'h0;
                core_addr  = word_addr(idx, $random(seed));
                core_wdata = $random(seed);
                core_cyc   = 1'b1;
                core_stb   = 1'b1;
                core_busy  = 1'b1;
                core_reqs++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (started) begin
            cmd_valid   = 1'b0;
            resp_credit = 1'b0;
            if (cmd_credit) cmd_credits++;
            check(cmd_credits >= 0 && cmd_credits <= CMD_DEPTH, 1'b1, "host command credits");
            if (resp_valid) take_resp();
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                resp_credit = 1'b1;
                resp_crd++;
            end
            core_step();
            if (sent < NUM_CMDS && cmd_credits > 0 && ($random(seed) & 3) != 0) send_cmd();
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d responses seen",
                     cycle, answered, NUM_CMDS);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        resp_credit = 1'b0;
        core_cyc    = 1'b0;
        core_stb    = 1'b0;
        core_we     = 1'b0;
        core_wstrb  = 4'h0;
        core_addr   = 32'd0;
        core_wdata  = 32'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check(core_rst, 1'b1, "core reset after reset");
        @(posedge clk);
        started = 1'b1;
        wait (answered == NUM_CMDS);
        repeat (20) @(posedge clk);
        check(sent_q.size(), 32'd0, "commands left unanswered");
        check(core_busy, 1'b0, "core request still open");
        check(core_acks, core_reqs, "core acks per request");
        check(cmd_credits, CMD_DEPTH, "command credits returned");
        $display("Done: %0d commands, %0d core requests, %0d errors, %0d assertion failures",
                 answered, core_reqs, errors, u_dut.u_sva.assert_fails);
        if (errors == 0 && u_dut.u_sva.assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tests/processorci_tb_sva.sv
`timescale 1ns/1ps

module processorci_tb_sva #(
    parameter int RESP_CREDITS = 2
) (
    input logic clk_i,
    input logic reset_i,
    input logic cmd_valid_i,
    input logic cmd_credit_i,
    input logic resp_valid_i,
    input logic resp_credit_i,
    input logic core_cyc_i,
    input logic core_stb_i,
    input logic core_ack_i
);

    int resp_avail;   // Response credits the DUT still holds
    int cmds_in;
    int credits_out;
    int assert_fails = 0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_avail  <= RESP_CREDITS;
            cmds_in     <= 0;
            credits_out <= 0;
        end else begin
            resp_avail  <= resp_avail - int'(resp_valid_i) + int'(resp_credit_i);
            cmds_in     <= cmds_in + int'(cmd_valid_i);
            credits_out <= credits_out + int'(cmd_credit_i);
        end
    end

    resp_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_i |-> resp_avail > 0)
        else begin
            $error("response sent while no credit was held");
            assert_fails++;
        end

    ack_not_back_to_back: assert property (@(posedge clk_i) disable iff (reset_i)
        core_ack_i |=> !core_ack_i)
        else begin
            $error("core ack high in two consecutive cycles");
            assert_fails++;
        end

    ack_follows_request: assert property (@(posedge clk_i) disable iff (reset_i)
        core_ack_i |-> $past(core_cyc_i && core_stb_i))
        else begin
            $error("core ack without a request in the cycle before");
            assert_fails++;
        end

    // A credit can only come back for a command already received
    credit_follows_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_credit_i |-> credits_out < cmds_in)
        else begin
            $error("more command credits returned than commands received");
            assert_fails++;
        end

endmodule

bind processorci_top processorci_tb_sva #(.RESP_CREDITS(RESP_CREDITS)) u_sva (
    .clk_i         (sys_clk),
    .reset_i       (reset_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_credit_i  (cmd_credit_o),
    .resp_valid_i  (resp_valid_o),
    .resp_credit_i (resp_credit_i),
    .core_cyc_i    (core_cyc_i),
    .core_stb_i    (core_stb_i),
    .core_ack_i    (core_ack_o)
);
